// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := bench_role_tb
FILELIST  := bench_role.f
BUILD_DIR := obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

// File: bench_role.f
verilog/bench_pkg.sv
verilog/stream_tap_if.sv
verilog/mem_bench_ctrl.sv
verilog/iperf_session_ctrl.sv
verilog/tcp_stream_stats.sv
verilog/bench_role.sv
tests/bench_role_tb.sv

// File: tests/bench_role_tb.sv
/* benchmark role testbench */

module bench_role_tb;

   localparam int NUM_CHANNELS = 2;
   localparam int NUM_CYCLES   = 3000;

   logic user_clk = 1'b0;
   logic user_aresetn;
   logic mem_cmd_valid, mem_cmd_ready, bench_is_write, mem_running;
   bench_pkg::mem_cmd_t mem_cmd_data;
   logic [1:0] mem_cmd_dest;
   logic [NUM_CHANNELS-1:0] done_valid, bench_start;
   bench_pkg::cycles_t [NUM_CHANNELS-1:0] done_cycles;
   bench_pkg::mem_addr_t bench_base_addr, bench_mem_size;
   bench_pkg::word32_t bench_num_accesses, bench_chunk_len, bench_stride, mem_active_cycles;
   bench_pkg::cycles_t mem_exec_cycles, time_in_cycles, iperf_exec_cycles;
   logic iperf_cmd_valid, iperf_cmd_ready, addr_valid, addr_ready;
   bench_pkg::iperf_cmd_t iperf_cmd_data;
   logic [bench_pkg::IP_DEST_W-1:0] addr_dest;
   bench_pkg::ip_addr_t addr_data;
   logic listen_valid, listen_ready, open_valid, open_ready, close_valid, close_ready;
   logic run_experiment, dual_mode;
   logic [15:0] conn_count, open_count;
   logic [7:0] pkg_word_count, packet_gap, listen_count;
   bench_pkg::word32_t time_in_seconds;
   bench_pkg::ip_addr_t [bench_pkg::IP_TABLE_DEPTH-1:0] ip_table;
   logic rx_valid, rx_ready, rx_last, tx_valid, tx_ready, tx_last;
   bench_pkg::keep_t rx_keep, tx_keep;
   logic tx_meta_valid, tx_meta_ready, tx_status_valid, tx_status_ready;
   bench_pkg::tx_status_t tx_status;
   bench_pkg::byte_count_t consumed_bytes, produced_bytes;
   bench_pkg::word32_t tx_cmd_count, tx_pkg_count, tx_sts_count, tx_sts_good_count;

   // reference model state one cycle ahead of the DUT outputs
   logic m_rdy, m_run, m_irun, m_run_exp, have_mem, have_ip;
   logic [NUM_CHANNELS-1:0] m_start;
   bench_pkg::mem_cmd_t m_mcmd;
   bench_pkg::iperf_cmd_t m_icmd;
   bench_pkg::cycles_t m_exec, m_timer, m_iexec;
   bench_pkg::word32_t m_active, m_cmds, m_pkgs, m_sts, m_good;
   bench_pkg::byte_count_t m_cons, m_prod;
   bench_pkg::ip_addr_t m_table [bench_pkg::IP_TABLE_DEPTH];
   logic [7:0] m_listen;
   logic [15:0] m_open;
   integer seed = 32'h2c7e10f9;

   always #2 user_clk = ~user_clk;

   bench_role #(.NUM_CHANNELS(NUM_CHANNELS)) i_bench_role (.*);

   task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
      if (got !== exp) begin
         $display("FAIL %s got %h expected %h", name, got, exp);
         $display("Test failed");
         $fatal(1, "value mismatch on %s", name);
      end
   endtask

   // byte count of a keep mask or zero for holes and empty masks
   function automatic bench_pkg::byte_count_t mask_bytes(input bench_pkg::keep_t k);
      case (k)
         8'h01: return 48'd1;
         8'h03: return 48'd2;
         8'h07: return 48'd3;
         8'h0f: return 48'd4;
         8'h1f: return 48'd5;
         8'h3f: return 48'd6;
         8'h7f: return 48'd7;
         8'hff: return 48'd8;
         default: return 48'd0;
      endcase
   endfunction

   task automatic init_inputs();
      user_aresetn    <= 1'b0;
      mem_cmd_valid   <= 1'b0;
      mem_cmd_data    <= '0;
      mem_cmd_dest    <= 2'd0;
      done_valid      <= '0;
      done_cycles     <= '0;
      iperf_cmd_valid <= 1'b0;
      iperf_cmd_data  <= '0;
      addr_valid      <= 1'b0;
      addr_dest       <= '0;
      addr_data       <= '0;
      {listen_valid, listen_ready, open_valid, open_ready} <= 4'd0;
      {close_valid, close_ready} <= 2'd0;
      {rx_valid, rx_ready, rx_last, tx_valid, tx_ready, tx_last} <= 6'd0;
      rx_keep         <= '0;
      tx_keep         <= '0;
      {tx_meta_valid, tx_meta_ready, tx_status_valid, tx_status_ready} <= 4'd0;
      tx_status       <= '0;
   endtask

   task automatic init_model();
      {m_rdy, m_run, m_irun, m_run_exp, have_mem, have_ip} = 6'd0;
      m_start  = '0;
      m_mcmd   = '0;
      m_icmd   = '0;
      {m_exec, m_timer, m_iexec} = '0;
      {m_active, m_cmds, m_pkgs, m_sts, m_good} = '0;
      {m_cons, m_prod} = '0;
      m_listen = '0;
      m_open   = '0;
      for (int i = 0; i < bench_pkg::IP_TABLE_DEPTH; i++) begin
         m_table[i] = bench_pkg::DEFAULT_IP;
      end
   endtask

   // new random inputs for the next clock edge
   task automatic drive_inputs();
      logic [31:0] r, w0, w1, w2, w3;
      r  = $random(seed);
      w0 = $random(seed);
      w1 = $random(seed);
      w2 = $random(seed);
      w3 = $random(seed);
      mem_cmd_valid                <= (r[2:0] == 3'd0);
      mem_cmd_dest                 <= {1'b0, r[3]};
      mem_cmd_data.base_addr       <= {w1[15:0], w0};
      mem_cmd_data.mem_size        <= {w0[15:0], w2};
      mem_cmd_data.num_accesses    <= w3;
      mem_cmd_data.chunk_len       <= w1;
      mem_cmd_data.stride          <= w2;
      mem_cmd_data.is_write        <= r[4];
      // engine reports only while a run is active and no command is sent
      done_valid <= (r[2:0] != 3'd0 && m_run && r[7:5] == 3'd0) ? r[9:8] : 2'b00;
      done_cycles[0]  <= {w0, w3};
      done_cycles[1]  <= {w2, w1};
      iperf_cmd_valid <= (r[12:10] == 3'd0);
      iperf_cmd_data  <= {w3, w2, w1, w0};
      close_valid     <= (r[12:10] != 3'd0) && (r[15:13] == 3'd0);
      close_ready     <= w3[31];
      addr_valid      <= r[16];
      addr_dest       <= 4'(w3 % 32'd10);
      addr_data       <= w0 ^ w2;
      {listen_valid, listen_ready, open_valid, open_ready} <= r[20:17];
      {rx_valid, rx_ready, rx_last} <= r[23:21];
      rx_keep <= r[24] ? (8'hff >> w1[2:0]) : w2[7:0];
      {tx_valid, tx_ready, tx_last} <= r[27:25];
      tx_keep <= r[28] ? (8'hff >> w3[2:0]) : w3[15:8];
      {tx_meta_valid, tx_meta_ready, tx_status_valid} <= r[31:29];
      tx_status_ready <= w0[31];
      tx_status       <= {w1, w2};
   endtask

   // advance the model by one clock edge using the current inputs
   task automatic step_model();
      bench_pkg::cycles_t old_timer;
      old_timer = m_timer;
      m_start   = '0;
      if (mem_cmd_valid && m_rdy) begin
         m_start[mem_cmd_dest[0]] = 1'b1;
         m_mcmd   = mem_cmd_data;
         have_mem = 1'b1;
         m_run    = 1'b1;
         m_exec   = '0;
         m_active = '0;
      end else if (m_run) begin
         m_active = m_active + 32'd1;
      end
      if (done_valid != '0) begin
         m_run  = 1'b0;
         m_exec = done_valid[1] ? done_cycles[1] : done_cycles[0];
      end
      m_run_exp = iperf_cmd_valid && m_rdy;
      if (m_run_exp) begin
         m_icmd  = iperf_cmd_data;
         have_ip = 1'b1;
         m_irun  = 1'b1;
         m_timer = '0;
         m_iexec = '0;
      end else if (m_irun) begin
         m_timer = m_timer + 64'd1;
      end
      if (close_valid && close_ready) begin
         m_irun  = 1'b0;
         m_iexec = old_timer;                     // value seen on the close cycle
      end
      if (addr_valid && m_rdy) m_table[addr_dest] = addr_data;
      if (listen_valid && listen_ready) m_listen = m_listen + 8'd1;
      if (open_valid && open_ready) m_open = m_open + 16'd1;
      if (rx_valid && rx_ready) m_cons = m_cons + mask_bytes(rx_keep);
      if (tx_valid && tx_ready) begin
         m_prod = m_prod + mask_bytes(tx_keep);
         if (tx_last) m_pkgs = m_pkgs + 32'd1;
      end
      if (tx_meta_valid && tx_meta_ready) m_cmds = m_cmds + 32'd1;
      if (tx_status_valid && tx_status_ready) begin
         m_sts = m_sts + 32'd1;
         if (tx_status[63:62] == 2'b00) m_good = m_good + 32'd1;
      end
      m_rdy = 1'b1;                               // ready from the first cycle after reset
   endtask

   task automatic compare_all();
      check("mem_cmd_ready", 64'(mem_cmd_ready), 64'(m_rdy));
      check("iperf_cmd_ready", 64'(iperf_cmd_ready), 64'(m_rdy));
      check("addr_ready", 64'(addr_ready), 64'(m_rdy));
      check("bench_start", 64'(bench_start), 64'(m_start));
      check("mem_running", 64'(mem_running), 64'(m_run));
      check("mem_exec_cycles", mem_exec_cycles, m_exec);
      check("mem_active_cycles", 64'(mem_active_cycles), 64'(m_active));
      if (have_mem) begin
         check("bench_base_addr", 64'(bench_base_addr), 64'(m_mcmd.base_addr));
         check("bench_mem_size", 64'(bench_mem_size), 64'(m_mcmd.mem_size));
         check("bench_num_accesses", 64'(bench_num_accesses), 64'(m_mcmd.num_accesses));
         check("bench_chunk_len", 64'(bench_chunk_len), 64'(m_mcmd.chunk_len));
         check("bench_stride", 64'(bench_stride), 64'(m_mcmd.stride));
         check("bench_is_write", 64'(bench_is_write), 64'(m_mcmd.is_write));
      end
      check("run_experiment", 64'(run_experiment), 64'(m_run_exp));
      check("iperf_exec_cycles", iperf_exec_cycles, m_iexec);
      check("listen_count", 64'(listen_count), 64'(m_listen));
      check("open_count", 64'(open_count), 64'(m_open));
      if (have_ip) begin
         check("dual_mode", 64'(dual_mode), 64'(m_icmd.dual_mode));
         check("conn_count", 64'(conn_count), 64'(m_icmd.conn_count));
         check("pkg_word_count", 64'(pkg_word_count), 64'(m_icmd.pkg_word_count));
         check("packet_gap", 64'(packet_gap), 64'(m_icmd.packet_gap));
         check("time_in_seconds", 64'(time_in_seconds), 64'(m_icmd.time_in_seconds));
         check("time_in_cycles", time_in_cycles, m_icmd.time_in_cycles);
      end
      for (int i = 0; i < bench_pkg::IP_TABLE_DEPTH; i++) begin
         check($sformatf("ip_table[%0d]", i), 64'(ip_table[i]), 64'(m_table[i]));
      end
      check("consumed_bytes", 64'(consumed_bytes), 64'(m_cons));
      check("produced_bytes", 64'(produced_bytes), 64'(m_prod));
      check("tx_cmd_count", 64'(tx_cmd_count), 64'(m_cmds));
      check("tx_pkg_count", 64'(tx_pkg_count), 64'(m_pkgs));
      check("tx_sts_count", 64'(tx_sts_count), 64'(m_sts));
      check("tx_sts_good_count", 64'(tx_sts_good_count), 64'(m_good));
   endtask

   initial begin
      init_inputs();
      init_model();
      repeat (3) @(posedge user_clk);
      user_aresetn <= 1'b1;
      @(negedge user_clk);
      compare_all();                              // reset state
      step_model();
      for (int t = 0; t < 10 && !(mem_cmd_ready && iperf_cmd_ready && addr_ready); t++) begin
         @(negedge user_clk);
         compare_all();
         step_model();
      end
      if (!(mem_cmd_ready && iperf_cmd_ready && addr_ready)) begin
         $display("Test failed");
         $fatal(1, "command ready outputs did not rise after reset");
      end
      for (int n = 0; n < NUM_CYCLES; n++) begin
         @(posedge user_clk);
         drive_inputs();
         @(negedge user_clk);                     // outputs settled
         compare_all();
         step_model();
      end
      $display("Test passed");
      $finish;
   end

endmodule

// File: verilog/bench_pkg.sv
/* benchmark role shared types */

package bench_pkg;

   typedef logic [47:0] mem_addr_t;   // address or size
   typedef logic [31:0] word32_t;     // count, length, stride
   typedef logic [63:0] cycles_t;
   typedef logic [47:0] byte_count_t;
   typedef logic [31:0] ip_addr_t;
   typedef logic [7:0]  keep_t;       // one bit per byte of a 64-bit word
   typedef logic [63:0] tx_status_t;

   typedef struct packed {
      logic      is_write;            // bit 192
      word32_t   stride;
      word32_t   chunk_len;
      word32_t   num_accesses;
      mem_addr_t mem_size;
      mem_addr_t base_addr;           // bits 47:0
   } mem_cmd_t;

   typedef struct packed {
      cycles_t     time_in_cycles;    // bits 127:64
      word32_t     time_in_seconds;
      logic [7:0]  packet_gap;
      logic [7:0]  pkg_word_count;
      logic [14:0] conn_count;
      logic        dual_mode;         // bit 0
   } iperf_cmd_t;

   typedef enum logic {ST_IDLE, ST_RUN} run_state_t;

   localparam int       IP_TABLE_DEPTH = 10;
   localparam int       IP_DEST_W      = 4;
   localparam ip_addr_t DEFAULT_IP     = 32'hC0A80006; // 192.168.0.6

endpackage

// File: verilog/bench_role.sv
/* benchmark role top level */

module bench_role #(
   parameter int NUM_CHANNELS = 2
) (
   input  logic                                  user_clk,
   input  logic                                  user_aresetn,
   // memory benchmark
   input  logic                                  mem_cmd_valid,
   output logic                                  mem_cmd_ready,
   input  bench_pkg::mem_cmd_t                   mem_cmd_data,
   input  logic [1:0]                            mem_cmd_dest,
   input  logic [NUM_CHANNELS-1:0]               done_valid,
   input  bench_pkg::cycles_t [NUM_CHANNELS-1:0] done_cycles,
   output bench_pkg::mem_addr_t                  bench_base_addr,
   output bench_pkg::mem_addr_t                  bench_mem_size,
   output bench_pkg::word32_t                    bench_num_accesses,
   output bench_pkg::word32_t                    bench_chunk_len,
   output bench_pkg::word32_t                    bench_stride,
   output logic                                  bench_is_write,
   output logic [NUM_CHANNELS-1:0]               bench_start,
   output logic                                  mem_running,
   output bench_pkg::cycles_t                    mem_exec_cycles,
   output bench_pkg::word32_t                    mem_active_cycles,
   // TCP client control
   input  logic                                  iperf_cmd_valid,
   output logic                                  iperf_cmd_ready,
   input  bench_pkg::iperf_cmd_t                 iperf_cmd_data,
   input  logic                                  addr_valid,
   output logic                                  addr_ready,
   input  logic [bench_pkg::IP_DEST_W-1:0]       addr_dest,
   input  bench_pkg::ip_addr_t                   addr_data,
   input  logic                                  listen_valid,
   input  logic                                  listen_ready,
   input  logic                                  open_valid,
   input  logic                                  open_ready,
   input  logic                                  close_valid,
   input  logic                                  close_ready,
   output logic                                  run_experiment,
   output logic                                  dual_mode,
   output logic [15:0]                           conn_count,
   output logic [7:0]                            pkg_word_count,
   output logic [7:0]                            packet_gap,
   output bench_pkg::word32_t                    time_in_seconds,
   output bench_pkg::cycles_t                    time_in_cycles,
   output bench_pkg::ip_addr_t [bench_pkg::IP_TABLE_DEPTH-1:0] ip_table,
   output bench_pkg::cycles_t                    iperf_exec_cycles,
   output logic [7:0]                            listen_count,
   output logic [15:0]                           open_count,
   // observed TCP streams
   input  logic                                  rx_valid,
   input  logic                                  rx_ready,
   input  bench_pkg::keep_t                      rx_keep,
   input  logic                                  rx_last,
   input  logic                                  tx_valid,
   input  logic                                  tx_ready,
   input  bench_pkg::keep_t                      tx_keep,
   input  logic                                  tx_last,
   input  logic                                  tx_meta_valid,
   input  logic                                  tx_meta_ready,
   input  logic                                  tx_status_valid,
   input  logic                                  tx_status_ready,
   input  bench_pkg::tx_status_t                 tx_status,
   output bench_pkg::byte_count_t                consumed_bytes,
   output bench_pkg::byte_count_t                produced_bytes,
   output bench_pkg::word32_t                    tx_cmd_count,
   output bench_pkg::word32_t                    tx_pkg_count,
   output bench_pkg::word32_t                    tx_sts_count,
   output bench_pkg::word32_t                    tx_sts_good_count
);

   stream_tap_if rx_tap ();
   stream_tap_if tx_tap ();

   assign rx_tap.valid = rx_valid;
   assign rx_tap.ready = rx_ready;
   assign rx_tap.keep  = rx_keep;
   assign rx_tap.last  = rx_last;
   assign tx_tap.valid = tx_valid;
   assign tx_tap.ready = tx_ready;
   assign tx_tap.keep  = tx_keep;
   assign tx_tap.last  = tx_last;

   mem_bench_ctrl #(.NUM_CHANNELS(NUM_CHANNELS)) i_mem_bench_ctrl (.*);

   iperf_session_ctrl i_iperf_session_ctrl (.*);

   tcp_stream_stats i_tcp_stream_stats (.*);

endmodule

// File: verilog/iperf_session_ctrl.sv
/* TCP client session control */

module iperf_session_ctrl (
   input  logic                       user_clk,
   input  logic                       user_aresetn,
   input  logic                       iperf_cmd_valid,
   output logic                       iperf_cmd_ready,
   input  bench_pkg::iperf_cmd_t      iperf_cmd_data,
   input  logic                       addr_valid,
   output logic                       addr_ready,
   input  logic [bench_pkg::IP_DEST_W-1:0] addr_dest,
   input  bench_pkg::ip_addr_t        addr_data,
   input  logic                       listen_valid,
   input  logic                       listen_ready,
   input  logic                       open_valid,
   input  logic                       open_ready,
   input  logic                       close_valid,
   input  logic                       close_ready,
   output logic                       run_experiment,
   output logic                       dual_mode,
   output logic [15:0]                conn_count,
   output logic [7:0]                 pkg_word_count,
   output logic [7:0]                 packet_gap,
   output bench_pkg::word32_t         time_in_seconds,
   output bench_pkg::cycles_t         time_in_cycles,
   output bench_pkg::ip_addr_t [bench_pkg::IP_TABLE_DEPTH-1:0] ip_table,
   output bench_pkg::cycles_t         iperf_exec_cycles,
   output logic [7:0]                 listen_count,
   output logic [15:0]                open_count
);

   bench_pkg::run_state_t state;
   bench_pkg::cycles_t    timer_cycles;
   logic                  cmd_fire;
   logic                  addr_fire;

   assign cmd_fire  = iperf_cmd_valid && iperf_cmd_ready;
   assign addr_fire = addr_valid && addr_ready;

   // experiment settings for the client
   always_ff @(posedge user_clk) begin
      if (cmd_fire) begin
         dual_mode       <= iperf_cmd_data.dual_mode;
         conn_count      <= {1'b0, iperf_cmd_data.conn_count};
         pkg_word_count  <= iperf_cmd_data.pkg_word_count;
         packet_gap      <= iperf_cmd_data.packet_gap;
         time_in_seconds <= iperf_cmd_data.time_in_seconds;
         time_in_cycles  <= iperf_cmd_data.time_in_cycles;
      end
   end

   always_ff @(posedge user_clk) begin
      if (!user_aresetn) begin
         iperf_cmd_ready   <= 1'b0;
         addr_ready        <= 1'b0;
         run_experiment    <= 1'b0;
         state             <= bench_pkg::ST_IDLE;
         timer_cycles      <= '0;
         iperf_exec_cycles <= '0;
         listen_count      <= '0;
         open_count        <= '0;
         ip_table          <= {bench_pkg::IP_TABLE_DEPTH{bench_pkg::DEFAULT_IP}};
      end else begin
         iperf_cmd_ready <= 1'b1;
         addr_ready      <= 1'b1;
         run_experiment  <= 1'b0;
         if (cmd_fire) begin
            run_experiment    <= 1'b1;
            state             <= bench_pkg::ST_RUN;
            timer_cycles      <= '0;
            iperf_exec_cycles <= '0;
         end else if (state == bench_pkg::ST_RUN) begin
            timer_cycles <= timer_cycles + 64'd1;
         end
         if (close_valid && close_ready) begin        // session ends on close
            state             <= bench_pkg::ST_IDLE;
            iperf_exec_cycles <= timer_cycles;
         end
         if (addr_fire) begin
            ip_table[addr_dest] <= addr_data;
         end
         if (listen_valid && listen_ready) begin
            listen_count <= listen_count + 8'd1;
         end
         if (open_valid && open_ready) begin
            open_count <= open_count + 16'd1;
         end
      end
   end

   a_slot_in_range: assert property (@(posedge user_clk) disable iff (!user_aresetn)
      addr_fire |-> int'(addr_dest) < bench_pkg::IP_TABLE_DEPTH);

endmodule

// File: verilog/mem_bench_ctrl.sv
/* memory benchmark command path */

module mem_bench_ctrl #(
   parameter int NUM_CHANNELS = 2
) (
   input  logic                                  user_clk,
   input  logic                                  user_aresetn,
   input  logic                                  mem_cmd_valid,
   output logic                                  mem_cmd_ready,
   input  bench_pkg::mem_cmd_t                   mem_cmd_data,
   input  logic [1:0]                            mem_cmd_dest,
   input  logic [NUM_CHANNELS-1:0]               done_valid,
   input  bench_pkg::cycles_t [NUM_CHANNELS-1:0] done_cycles,
   output bench_pkg::mem_addr_t                  bench_base_addr,
   output bench_pkg::mem_addr_t                  bench_mem_size,
   output bench_pkg::word32_t                    bench_num_accesses,
   output bench_pkg::word32_t                    bench_chunk_len,
   output bench_pkg::word32_t                    bench_stride,
   output logic                                  bench_is_write,
   output logic [NUM_CHANNELS-1:0]               bench_start,
   output logic                                  mem_running,
   output bench_pkg::cycles_t                    mem_exec_cycles,
   output bench_pkg::word32_t                    mem_active_cycles
);

   bench_pkg::run_state_t state;
   logic                  cmd_fire;

   assign cmd_fire    = mem_cmd_valid && mem_cmd_ready;
   assign mem_running = (state == bench_pkg::ST_RUN);

   // access parameters shared by every engine
   always_ff @(posedge user_clk) begin
      if (cmd_fire) begin
         bench_base_addr    <= mem_cmd_data.base_addr;
         bench_mem_size     <= mem_cmd_data.mem_size;
         bench_num_accesses <= mem_cmd_data.num_accesses;
         bench_chunk_len    <= mem_cmd_data.chunk_len;
         bench_stride       <= mem_cmd_data.stride;
         bench_is_write     <= mem_cmd_data.is_write;
      end
   end

   always_ff @(posedge user_clk) begin
      if (!user_aresetn) begin
         mem_cmd_ready     <= 1'b0;
         bench_start       <= '0;
         state             <= bench_pkg::ST_IDLE;
         mem_exec_cycles   <= '0;
         mem_active_cycles <= '0;
      end else begin
         mem_cmd_ready <= 1'b1;
         bench_start   <= '0;                          // single-cycle pulse
         if (cmd_fire) begin
            bench_start       <= NUM_CHANNELS'(1) << mem_cmd_dest;
            state             <= bench_pkg::ST_RUN;
            mem_exec_cycles   <= '0;
            mem_active_cycles <= '0;
         end else if (mem_running) begin
            mem_active_cycles <= mem_active_cycles + 32'd1;
         end
         for (int i = 0; i < NUM_CHANNELS; i++) begin
            if (done_valid[i]) begin                  // higher index wins
               mem_exec_cycles <= done_cycles[i];
               state           <= bench_pkg::ST_IDLE;
            end
         end
      end
   end

   a_dest_in_range: assert property (@(posedge user_clk) disable iff (!user_aresetn)
      cmd_fire |-> int'(mem_cmd_dest) < NUM_CHANNELS);

endmodule

// File: verilog/stream_tap_if.sv
/* observed 64-bit stream */

interface stream_tap_if;

   logic              valid;
   logic              ready;
   bench_pkg::keep_t  keep;
   logic              last;

   // taps only watch the stream
   modport monitor (
      input valid,
      input ready,
      input keep,
      input last
   );

endinterface

// File: verilog/tcp_stream_stats.sv
/* TCP stream statistics */

module tcp_stream_stats (
   input  logic                   user_clk,
   input  logic                   user_aresetn,
   stream_tap_if.monitor          rx_tap,
   stream_tap_if.monitor          tx_tap,
   input  logic                   tx_meta_valid,
   input  logic                   tx_meta_ready,
   input  logic                   tx_status_valid,
   input  logic                   tx_status_ready,
   input  bench_pkg::tx_status_t  tx_status,
   output bench_pkg::byte_count_t consumed_bytes,
   output bench_pkg::byte_count_t produced_bytes,
   output bench_pkg::word32_t     tx_cmd_count,
   output bench_pkg::word32_t     tx_pkg_count,
   output bench_pkg::word32_t     tx_sts_count,
   output bench_pkg::word32_t     tx_sts_good_count
);

   // enabled bytes of a mask filled from bit 0
   function automatic bench_pkg::byte_count_t keep_bytes(input bench_pkg::keep_t keep);
      bench_pkg::keep_t next_mask;
      next_mask = keep + 8'd1;
      if (keep != '0 && (keep & next_mask) == '0) begin
         return bench_pkg::byte_count_t'($countones(keep));
      end
      return '0;                                      // holes count nothing
   endfunction

   logic rx_fire;
   logic tx_fire;
   logic sts_fire;

   assign rx_fire  = rx_tap.valid && rx_tap.ready;
   assign tx_fire  = tx_tap.valid && tx_tap.ready;
   assign sts_fire = tx_status_valid && tx_status_ready;

   always_ff @(posedge user_clk) begin
      if (!user_aresetn) begin
         consumed_bytes    <= '0;
         produced_bytes    <= '0;
         tx_cmd_count      <= '0;
         tx_pkg_count      <= '0;
         tx_sts_count      <= '0;
         tx_sts_good_count <= '0;
      end else begin
         if (rx_fire) begin
            consumed_bytes <= consumed_bytes + keep_bytes(rx_tap.keep);
         end
         if (tx_fire) begin
            produced_bytes <= produced_bytes + keep_bytes(tx_tap.keep);
            if (tx_tap.last) begin
               tx_pkg_count <= tx_pkg_count + 32'd1;
            end
         end
         if (tx_meta_valid && tx_meta_ready) begin
            tx_cmd_count <= tx_cmd_count + 32'd1;
         end
         if (sts_fire) begin
            tx_sts_count <= tx_sts_count + 32'd1;
            if (tx_status[63:62] == 2'b00) begin      // no error code
               tx_sts_good_count <= tx_sts_good_count + 32'd1;
            end
         end
      end
   end

endmodule
